// File: cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN     = 32;
	localparam int NUM_REGS = 32;
	localparam int REG_AW   = 5;
	localparam int IM_AW    = 10;
	localparam int DM_AW    = 12;
	localparam int PC_STEP  = 4;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [IM_AW-1:0]  im_addr_t;
	typedef logic [DM_AW-1:0]  dm_addr_t;

	// instruction bits 31..26
	typedef enum logic [5:0] {
		op_lwi  = 6'h02,
		op_swi  = 6'h0a,
		op_alu  = 6'h20,
		op_movi = 6'h22,
		op_addi = 6'h28,
		op_nop  = 6'h3f
	} opcode_e;

	// instruction bits 4..0 for op_alu
	typedef enum logic [4:0] {
		alu_add = 5'h00,
		alu_sub = 5'h01,
		alu_and = 5'h02,
		alu_xor = 5'h03,
		alu_or  = 5'h04,
		alu_slt = 5'h06
	} alu_op_e;

	typedef enum logic {
		wb_alu = 1'b0,
		wb_mem = 1'b1
	} wb_sel_e;

	typedef struct packed {
		logic  valid;
		word_t instruction;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		alu_op_e   alu_op;
		word_t     ra_val;
		word_t     rt_val;
		word_t     imm;
		logic      use_imm;
		reg_addr_t rd;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		wb_sel_e   wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t rd;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		wb_sel_e   wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		word_t     wr_data;
		reg_addr_t rd;
		logic      reg_write;
	} mem_wb_t;

endpackage

// File: reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rt_addr,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data,
	output word_t     ra_data,
	output word_t     rt_data
);

	word_t regs [NUM_REGS];

	// write-through so a reader three instructions behind sees the value
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (wr_en && addr == wr_addr) begin
			return wr_data;
		end else begin
			return regs[addr];
		end
	endfunction

	always_comb ra_data = read_port(ra_addr);
	always_comb rt_data = read_port(rt_addr);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// File: fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    instruction,
	output im_addr_t IM_address,
	output if_id_t   if_id
);

	im_addr_t pc;

	assign IM_address = pc;

	// no branches, so the pc only ever steps forward
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else begin
			pc <= pc + im_addr_t'(PC_STEP);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else begin
			if_id.valid       <= 1'b1;
			if_id.instruction <= instruction;
		end
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  if_id_t  if_id,
	input  mem_wb_t mem_wb,
	output id_ex_t  id_ex
);

	word_t     instr;
	opcode_e   opcode;
	alu_op_e   sub_op;
	reg_addr_t rt;
	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rt_port_addr;
	word_t     imm15_ext;
	word_t     imm20_ext;
	word_t     ra_data;
	word_t     rt_data;
	logic      wb_en;
	id_ex_t    id_ex_next;

	assign instr  = if_id.instruction;
	assign opcode = opcode_e'(instr[31:26]);
	assign sub_op = alu_op_e'(instr[4:0]);
	assign rt     = instr[25:21];
	assign ra     = instr[20:16];
	assign rb     = instr[15:11];

	assign imm15_ext = {{(XLEN-15){instr[14]}}, instr[14:0]};
	assign imm20_ext = {{(XLEN-20){instr[19]}}, instr[19:0]};

	// second read port serves rb for alu ops, rt (store data) otherwise
	assign rt_port_addr = (opcode == op_alu) ? rb : rt;

	assign wb_en = mem_wb.valid && mem_wb.reg_write;

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_addr (ra),
		.rt_addr (rt_port_addr),
		.wr_en   (wb_en),
		.wr_addr (mem_wb.rd),
		.wr_data (mem_wb.wr_data),
		.ra_data (ra_data),
		.rt_data (rt_data)
	);

	always_comb begin
		id_ex_next         = '0;
		id_ex_next.valid   = if_id.valid;
		id_ex_next.alu_op  = alu_add;
		id_ex_next.ra_val  = ra_data;
		id_ex_next.rt_val  = rt_data;
		id_ex_next.imm     = imm15_ext;
		id_ex_next.rd      = rt;
		id_ex_next.wb_sel  = wb_alu;

		case (opcode)
			op_alu: begin
				case (sub_op)
					alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt: begin
						id_ex_next.alu_op    = sub_op;
						id_ex_next.reg_write = 1'b1;
					end
					// unknown sub-op does nothing
					default: id_ex_next.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				id_ex_next.use_imm   = 1'b1;
				id_ex_next.reg_write = 1'b1;
			end
			op_movi: begin
				// 0 + imm20, ra field overlaps the immediate
				id_ex_next.ra_val    = '0;
				id_ex_next.imm       = imm20_ext;
				id_ex_next.use_imm   = 1'b1;
				id_ex_next.reg_write = 1'b1;
			end
			op_lwi: begin
				id_ex_next.imm       = imm15_ext << 2;
				id_ex_next.use_imm   = 1'b1;
				id_ex_next.mem_read  = 1'b1;
				id_ex_next.reg_write = 1'b1;
				id_ex_next.wb_sel    = wb_mem;
			end
			op_swi: begin
				id_ex_next.imm       = imm15_ext << 2;
				id_ex_next.use_imm   = 1'b1;
				id_ex_next.mem_write = 1'b1;
			end
			default: id_ex_next.reg_write = 1'b0;
		endcase

		// r0 is never written
		if (rt == '0) begin
			id_ex_next.reg_write = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

endmodule

// File: execute_stage.sv
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  id_ex_t  id_ex,
	output ex_mem_t ex_mem,
	output logic    alu_overflow
);

	word_t   op_a;
	word_t   op_b;
	word_t   result;
	logic    ovf;
	logic    ovf_q;
	logic    ex_ovf;
	ex_mem_t ex_mem_next;

	assign op_a = id_ex.ra_val;
	assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rt_val;

	always_comb begin
		ovf = 1'b0;
		case (id_ex.alu_op)
			alu_add: begin
				result = op_a + op_b;
				ovf    = (op_a[XLEN-1] == op_b[XLEN-1]) && (result[XLEN-1] != op_a[XLEN-1]);
			end
			alu_sub: begin
				result = op_a - op_b;
				ovf    = (op_a[XLEN-1] != op_b[XLEN-1]) && (result[XLEN-1] != op_a[XLEN-1]);
			end
			alu_and: result = op_a & op_b;
			alu_or:  result = op_a | op_b;
			alu_xor: result = op_a ^ op_b;
			alu_slt: result = word_t'($signed(op_a) < $signed(op_b));
			default: result = '0;
		endcase
	end

	// address adds for lwi/swi don't count as overflow
	assign ovf_q = ovf && id_ex.valid && !id_ex.mem_read && !id_ex.mem_write;

	always_comb begin
		ex_mem_next            = '0;
		ex_mem_next.valid      = id_ex.valid;
		ex_mem_next.alu_result = result;
		ex_mem_next.store_data = id_ex.rt_val;
		ex_mem_next.rd         = id_ex.rd;
		ex_mem_next.reg_write  = id_ex.reg_write;
		ex_mem_next.mem_read   = id_ex.mem_read;
		ex_mem_next.mem_write  = id_ex.mem_write;
		ex_mem_next.wb_sel     = id_ex.wb_sel;
	end

	// flag rides with ex_mem, then one more stage to the port
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem       <= '0;
			ex_ovf       <= 1'b0;
			alu_overflow <= 1'b0;
		end else begin
			ex_mem       <= ex_mem_next;
			ex_ovf       <= ovf_q;
			alu_overflow <= ex_ovf;
		end
	end

endmodule

// File: memory_stage.sv
`timescale 1ns/10ps

module memory_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  ex_mem_t  ex_mem,
	output logic     DM_read,
	output logic     DM_write,
	output dm_addr_t DM_address,
	output word_t    DM_in,
	input  word_t    DM_out,
	output mem_wb_t  mem_wb
);

	mem_wb_t mem_wb_next;

	assign DM_read    = ex_mem.valid && ex_mem.mem_read;
	assign DM_write   = ex_mem.valid && ex_mem.mem_write;
	assign DM_address = ex_mem.alu_result[DM_AW-1:0];
	assign DM_in      = ex_mem.store_data;

	// zero-wait memory, load data is ready in this cycle
	always_comb begin
		mem_wb_next.valid     = ex_mem.valid;
		mem_wb_next.wr_data   = (ex_mem.wb_sel == wb_mem) ? DM_out : ex_mem.alu_result;
		mem_wb_next.rd        = ex_mem.rd;
		mem_wb_next.reg_write = ex_mem.valid && ex_mem.reg_write;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb <= mem_wb_next;
		end
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    instruction,
	output im_addr_t IM_address,
	output logic     DM_read,
	output logic     DM_write,
	output dm_addr_t DM_address,
	output word_t    DM_in,
	input  word_t    DM_out,
	output logic     alu_overflow
);

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	fetch_stage u_fetch (
		.clk         (clk),
		.arst_n      (arst_n),
		.instruction (instruction),
		.IM_address  (IM_address),
		.if_id       (if_id)
	);

	// mem_wb loops back here as the register write port
	decode_stage u_decode (
		.clk    (clk),
		.arst_n (arst_n),
		.if_id  (if_id),
		.mem_wb (mem_wb),
		.id_ex  (id_ex)
	);

	execute_stage u_execute (
		.clk          (clk),
		.arst_n       (arst_n),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.alu_overflow (alu_overflow)
	);

	memory_stage u_memory (
		.clk        (clk),
		.arst_n     (arst_n),
		.ex_mem     (ex_mem),
		.DM_read    (DM_read),
		.DM_write   (DM_write),
		.DM_address (DM_address),
		.DM_in      (DM_in),
		.DM_out     (DM_out),
		.mem_wb     (mem_wb)
	);

endmodule

// File: tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

	localparam int PROG_WORDS = 256;
	localparam int BODY_LEN   = 200;
	localparam int END_IDX    = BODY_LEN + 3 + NUM_REGS - 1;
	localparam int FINAL_BASE = 900;
	localparam int DM_WORDS   = 1024;
	localparam int TIMEOUT    = 400;
	localparam word_t NOP_WORD = {op_nop, 26'd0};

	logic     clk;
	logic     arst_n;
	word_t    instruction = NOP_WORD;
	im_addr_t IM_address;
	logic     DM_read;
	logic     DM_write;
	dm_addr_t DM_address;
	word_t    DM_in;
	word_t    DM_out = '0;
	logic     alu_overflow;

	word_t       prog [PROG_WORDS];
	word_t       dm [DM_WORDS];
	word_t       exp_mem [DM_WORDS];
	dm_addr_t    exp_addr [$];
	word_t       exp_data [$];
	int          exp_ovf;
	int          ready_at [NUM_REGS];
	int          store_idx = 0;
	int          ovf_count = 0;
	logic [31:0] seed = 32'h2d2839d1;

	cpu_top dut0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.instruction  (instruction),
		.IM_address   (IM_address),
		.DM_read      (DM_read),
		.DM_write     (DM_write),
		.DM_address   (DM_address),
		.DM_in        (DM_in),
		.DM_out       (DM_out),
		.alu_overflow (alu_overflow)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic reg_addr_t rand_reg();
		logic [31:0] r;
		r = next_random();
		return r[31:27];
	endfunction

	// odd multiplier keeps every word distinct
	function automatic word_t fill_word(input int k);
		return (word_t'(k) * 32'h9e3779b1) ^ (word_t'(k) << 21) ^ 32'h1b873593;
	endfunction

	function automatic word_t enc_alu(input alu_op_e sub, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb);
		return {op_alu, rt, ra, rb, 6'd0, sub};
	endfunction

	function automatic word_t enc_imm(input opcode_e op, input reg_addr_t rt,
			input reg_addr_t ra, input logic [14:0] imm);
		return {op, rt, ra, 1'b0, imm};
	endfunction

	function automatic word_t enc_movi(input reg_addr_t rt, input logic [19:0] imm);
		return {op_movi, rt, 1'b0, imm};
	endfunction

	// the memory stage holds the instruction fetched three words before the pc
	function automatic logic load_in_memory(input im_addr_t pc);
		word_t ins;
		if (pc < im_addr_t'(12)) begin
			return 1'b0;
		end
		ins = prog[pc[9:2] - 8'd3];
		return ins[31:26] == op_lwi;
	endfunction

	// only registers written at least three slots back
	function automatic reg_addr_t pick_source(input int idx);
		reg_addr_t r;
		for (int t = 0; t < 8; t++) begin
			r = rand_reg();
			if (ready_at[r] <= idx) return r;
		end
		return '0;
	endfunction

	function automatic void build_program();
		logic [31:0] r;
		reg_addr_t   rd;
		reg_addr_t   ra;
		reg_addr_t   rb;
		alu_op_e     sub;
		logic [14:0] slot;
		for (int k = 0; k < NUM_REGS; k++) ready_at[k] = 0;
		for (int i = 0; i < PROG_WORDS; i++) prog[i] = NOP_WORD;
		for (int i = 0; i < BODY_LEN; i++) begin
			r = next_random();
			rd = rand_reg();
			ra = pick_source(i);
			rb = pick_source(i);
			case (int'(r[27:25]) % 6)
				0: sub = alu_add;
				1: sub = alu_sub;
				2: sub = alu_and;
				3: sub = alu_or;
				4: sub = alu_xor;
				default: sub = alu_slt;
			endcase
			if (r[31:28] < 4'd6) begin
				prog[i] = enc_alu(sub, rd, ra, rb);
			end else if (r[31:28] < 4'd9) begin
				prog[i] = enc_imm(op_addi, rd, ra, r[14:0]);
			end else if (r[31:28] < 4'd11) begin
				prog[i] = enc_movi(rd, r[19:0]);
			end else if (r[31:28] < 4'd13) begin
				prog[i] = enc_imm(op_lwi, rd, '0, r[14:0]);
			end else if (r[31:28] < 4'd15) begin
				// store data register sits in the rt field
				prog[i] = enc_imm(op_swi, rb, '0, r[14:0]);
				rd = '0;
			end else begin
				rd = '0;
			end
			if (rd != '0) ready_at[rd] = i + 3;
		end
		// three nops, then dump every register
		for (int k = 1; k < NUM_REGS; k++) begin
			slot = 15'(FINAL_BASE + k);
			prog[BODY_LEN + 2 + k] = enc_imm(op_swi, reg_addr_t'(k), '0, slot);
		end
	endfunction

	function automatic void run_isa_model();
		word_t       regs [NUM_REGS];
		word_t       ins;
		word_t       a;
		word_t       b;
		word_t       addr;
		word_t       res;
		logic [32:0] wide;
		logic        wr;
		reg_addr_t   rt;
		for (int k = 0; k < NUM_REGS; k++) regs[k] = '0;
		for (int k = 0; k < DM_WORDS; k++) exp_mem[k] = fill_word(k);
		exp_ovf = 0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			ins = prog[i];
			rt = ins[25:21];
			a = regs[ins[20:16]];
			b = regs[ins[15:11]];
			addr = a + ({{17{ins[14]}}, ins[14:0]} << 2);
			wide = '0;
			res = '0;
			wr = 1'b1;
			case (opcode_e'(ins[31:26]))
				op_alu: begin
					case (alu_op_e'(ins[4:0]))
						alu_add: begin
							wide = {a[31], a} + {b[31], b};
							if (wide[32] != wide[31]) exp_ovf++;
						end
						alu_sub: begin
							wide = {a[31], a} - {b[31], b};
							if (wide[32] != wide[31]) exp_ovf++;
						end
						alu_and: wide = {1'b0, a & b};
						alu_or:  wide = {1'b0, a | b};
						alu_xor: wide = {1'b0, a ^ b};
						alu_slt: wide = {32'd0, $signed(a) < $signed(b)};
						default: wr = 1'b0;
					endcase
					res = wide[31:0];
				end
				op_addi: begin
					wide = {a[31], a} + {{18{ins[14]}}, ins[14:0]};
					res = wide[31:0];
					if (wide[32] != wide[31]) exp_ovf++;
				end
				op_movi: res = {{12{ins[19]}}, ins[19:0]};
				op_lwi:  res = exp_mem[addr[11:2]];
				op_swi: begin
					exp_addr.push_back(addr[11:0]);
					exp_data.push_back(regs[rt]);
					exp_mem[addr[11:2]] = regs[rt];
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && rt != '0) regs[rt] = res;
		end
	endfunction

	// zero-wait memories, driven on the falling edge
	always @(negedge clk) begin
		if (!arst_n) begin
			for (int k = 0; k < DM_WORDS; k++) dm[k] = fill_word(k);
		end else if (DM_write) begin
			dm[DM_address[11:2]] = DM_in;
		end
		instruction <= prog[IM_address[9:2]];
		DM_out <= dm[DM_address[11:2]];
	end

	always @(negedge clk) begin
		if (arst_n) begin
			assert (DM_read == load_in_memory(IM_address)) else
				fail_run($sformatf("error at %0t: DM_read is %b, expected %b",
					$time, DM_read, load_in_memory(IM_address)));
		end
		if (arst_n && DM_write) begin
			assert (store_idx < exp_addr.size()) else
				fail_run($sformatf("store to %h with data %h was not expected",
					DM_address, DM_in));
			assert (DM_address == exp_addr[store_idx]) else
				fail_run($sformatf("error at %0t: DM_address is %h, expected %h",
					$time, DM_address, exp_addr[store_idx]));
			assert (DM_in == exp_data[store_idx]) else
				fail_run($sformatf("error at %0t: DM_in is %h, expected %h",
					$time, DM_in, exp_data[store_idx]));
			store_idx++;
		end
		if (arst_n && alu_overflow) ovf_count++;
	end

	initial begin
		int cycles;
		arst_n = 1'b0;
		build_program();
		run_isa_model();
		repeat (10) @(negedge clk);
		arst_n <= 1'b1;
		for (int k = 0; k < 8; k++) begin
			assert (int'(IM_address) == 4 * k) else
				fail_run($sformatf("error at %0t: IM_address is %0d, expected %0d",
					$time, IM_address, 4 * k));
			// nothing can reach memory in the first three cycles
			if (k < 3) begin
				assert (!DM_read) else
					fail_run($sformatf("error at %0t: DM_read is %b, expected 0",
						$time, DM_read));
				assert (!DM_write) else
					fail_run($sformatf("error at %0t: DM_write is %b, expected 0",
						$time, DM_write));
				assert (!alu_overflow) else
					fail_run($sformatf("error at %0t: alu_overflow is %b, expected 0",
						$time, alu_overflow));
			end
			@(negedge clk);
		end
		cycles = 0;
		while (int'(IM_address) < 4 * (END_IDX + 8) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (int'(IM_address) >= 4 * (END_IDX + 8)) else
			fail_run("timed out waiting for the program to run to its end");
		assert (ovf_count == exp_ovf) else
			fail_run($sformatf("error at %0t: alu_overflow count is %0d, expected %0d",
				$time, ovf_count, exp_ovf));
		for (int k = 0; k < DM_WORDS; k++) begin
			assert (dm[k] == exp_mem[k]) else
				fail_run($sformatf("error at %0t: dm[%0d] is %h, expected %h",
					$time, k, dm[k], exp_mem[k]));
		end
		if (store_idx == exp_addr.size()) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			fail_run($sformatf("only %0d of %0d expected stores were seen",
				store_idx, exp_addr.size()));
		end
	end

endmodule

// File: build.f
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_cpu -f build.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_cpu 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Finished with no errors"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
